/* src/lmem_macros.svh */
// Local-memory shim constants
// Widths, bank count and pipeline depths shared by packages and RTL

`ifndef LMEM_MACROS_SVH
`define LMEM_MACROS_SVH

// ========================================
// Bank organisation
// ========================================

// Number of independent memory banks
`define LMEM_NUM_BANKS 2

// ========================================
// Avalon-MM field widths
// ========================================

// Word address
`define LMEM_ADDR_W 27
// Data beat, reduced for this shim
`define LMEM_DATA_W 64
// One enable bit per byte lane
`define LMEM_BYTE_W (`LMEM_DATA_W / 8)
// Burst count passes through untouched
`define LMEM_BURST_W 7

// ========================================
// Pipeline depths
// ========================================

`define LMEM_RD_PIPE_DEPTH 2
`define LMEM_RESET_SYNC_LEN 2

`endif

/* src/lmem_bus_pkg.sv */
// Avalon-MM bus types for the local-memory shim
// Command and read response structs plus the command opcode

`include "lmem_macros.svh"

package lmem_bus_pkg;

   // ========================================
   // Opcode
   // ========================================

   // Replaces the separate read and write strobes
   // Only one of the two may be active at a time on Avalon-MM
   typedef enum logic [1:0]
   {
      OP_IDLE  = 2'd0,
      OP_READ  = 2'd1,
      OP_WRITE = 2'd2
   } avmm_op_e;

   // ========================================
   // Command
   // ========================================

   // One Avalon-MM request as seen by master and slave
   // 2 + 27 + 7 + 64 + 8 = 108 bits
   typedef struct packed
   {
      avmm_op_e                  op;
      // Word address within the bank
      logic [`LMEM_ADDR_W-1:0]   address;
      // Burst length, not split by the shim
      logic [`LMEM_BURST_W-1:0]  burstcount;
      // Write payload, ignored on reads
      logic [`LMEM_DATA_W-1:0]   writedata;
      logic [`LMEM_BYTE_W-1:0]   byteenable;
   } lmem_cmd_t;

   // ========================================
   // Read response
   // ========================================

   // Maps readdatavalid and readdata, 65 bits
   typedef struct packed
   {
      logic                      valid;
      logic [`LMEM_DATA_W-1:0]   readdata;
   } lmem_rsp_t;

endpackage

/* src/lmem_ctrl_pkg.sv */
// Control types for the local-memory shim
// Bridge slot occupancy and the bank index type

`include "lmem_macros.svh"

package lmem_ctrl_pkg;

   // ========================================
   // Bridge slot state
   // ========================================

   // How many command slots currently hold a request
   // SLOT_ONE means only the output slot is in use
   // SLOT_TWO means the skid slot is in use as well
   typedef enum logic [1:0]
   {
      SLOT_EMPTY = 2'd0,
      SLOT_ONE   = 2'd1,
      SLOT_TWO   = 2'd2
   } slot_state_e;

   // ========================================
   // Bank index
   // ========================================

   // At least one bit, even for a single bank
   localparam int BANK_IDX_W =
      ($clog2(`LMEM_NUM_BANKS) > 0) ? $clog2(`LMEM_NUM_BANKS) : 1;

   // Selects one bank of the packed port arrays
   typedef logic [BANK_IDX_W-1:0] bank_idx_t;

endpackage

/* src/lmem_reset_pipe.sv */
// Per-bank reset pipeline
// Synchronizer chain followed by a fanout register that drives the bank reset

`include "lmem_macros.svh"

module lmem_reset_pipe
(
   input  logic Clk_100,
   input  logic reset,
   output logic bank_reset
);

   // ========================================
   // Synchronizer chain
   // ========================================

   localparam int SYNC_LEN = `LMEM_RESET_SYNC_LEN;

   // Bit 0 is the first stage, the top bit feeds the fanout register
   logic [SYNC_LEN-1:0] sync_q;

   // Global reset sets every stage at once
   // Afterwards zeros ripple in from the bottom, one stage per cycle
   // Total release latency is SYNC_LEN stages plus the fanout register
   always_ff @(posedge Clk_100)
   begin
      if (reset)
      begin
         sync_q     <= '1;
         // Fanout register is set too, so the bank reset
         // rises together with the global reset
         bank_reset <= 1'b1;
      end
      else
      begin
         sync_q     <= sync_q << 1;
         // Dedicated register, kept per bank so placement
         // can put the high-fanout net close to its bridge
         bank_reset <= sync_q[SYNC_LEN-1];
      end
   end

endmodule

/* src/lmem_avmm_bridge.sv */
// Pipelined Avalon-MM bridge for one memory bank
// Two-slot registered command path and a fixed-depth read-data pipe

`include "lmem_macros.svh"

module lmem_avmm_bridge
   import lmem_bus_pkg::*;
   import lmem_ctrl_pkg::*;
(
   input  logic      Clk_100,
   input  logic      bank_reset,
   // Region side
   input  lmem_cmd_t s_cmd,
   output logic      s_waitrequest,
   output lmem_rsp_t s_rsp,
   // Memory side
   output lmem_cmd_t m_cmd,
   input  logic      m_waitrequest,
   input  lmem_rsp_t m_rsp
);

   localparam int RD_DEPTH = `LMEM_RD_PIPE_DEPTH;

   // ========================================
   // Command slots
   // ========================================

   slot_state_e state_q;
   slot_state_e state_d;

   // Output slot drives m_cmd, skid slot catches one extra command
   lmem_cmd_t out_slot;
   lmem_cmd_t skid_slot;

   logic s_accept;
   logic m_accept;

   // Slot load controls
   logic load_out_s;
   logic load_out_skid;
   logic load_skid;

   // Handshakes on both sides
   assign s_accept = (s_cmd.op != OP_IDLE) && !s_waitrequest;
   assign m_accept = (state_q != SLOT_EMPTY) && !m_waitrequest;

   // Slot occupancy and load selection
   always_comb
   begin
      state_d       = state_q;
      load_out_s    = 1'b0;
      load_out_skid = 1'b0;
      load_skid     = 1'b0;
      case (state_q)
         SLOT_EMPTY:
         begin
            if (s_accept)
            begin
               load_out_s = 1'b1;
               state_d    = SLOT_ONE;
            end
         end
         SLOT_ONE:
         begin
            if (m_accept && s_accept)
            begin
               // Output slot is replaced in the same cycle it drains
               load_out_s = 1'b1;
            end
            else if (m_accept)
            begin
               state_d = SLOT_EMPTY;
            end
            else if (s_accept)
            begin
               // Memory stalled, park the new command in the skid slot
               load_skid = 1'b1;
               state_d   = SLOT_TWO;
            end
         end
         SLOT_TWO:
         begin
            // s_waitrequest is high here, only the memory side moves
            if (m_accept)
            begin
               load_out_skid = 1'b1;
               state_d       = SLOT_ONE;
            end
         end
         default:
         begin
            state_d = SLOT_EMPTY;
         end
      endcase
   end

   // Slot payload
   always_ff @(posedge Clk_100)
   begin
      if (load_out_s)
         out_slot <= s_cmd;
      else if (load_out_skid)
         out_slot <= skid_slot;
      if (load_skid)
         skid_slot <= s_cmd;
   end

   // Occupancy and waitrequest
   // Waitrequest looks at the next state, so it is high exactly when
   // both slots are full after this edge
   always_ff @(posedge Clk_100)
   begin
      if (bank_reset)
      begin
         state_q       <= SLOT_EMPTY;
         s_waitrequest <= 1'b1;
      end
      else
      begin
         state_q       <= state_d;
         s_waitrequest <= (state_d == SLOT_TWO);
      end
   end

   // Memory sees the output slot, idle when nothing is held
   always_comb
   begin
      m_cmd = out_slot;
      if (state_q == SLOT_EMPTY)
         m_cmd.op = OP_IDLE;
   end

   // ========================================
   // Read-data pipe
   // ========================================

   // Plain shift register, so latency is fixed and ignores back-pressure
   lmem_rsp_t rsp_pipe [RD_DEPTH];

   always_ff @(posedge Clk_100)
   begin
      rsp_pipe[0] <= m_rsp;
      for (int i = 1; i < RD_DEPTH; i++)
         rsp_pipe[i] <= rsp_pipe[i-1];
      // Only the valid bits are cleared, data follows freely
      if (bank_reset)
      begin
         for (int i = 0; i < RD_DEPTH; i++)
            rsp_pipe[i].valid <= 1'b0;
      end
   end

   // Last stage back to the region
   assign s_rsp = rsp_pipe[RD_DEPTH-1];

endmodule

/* src/lmem_shim_top.sv */
// Multi-bank local-memory shim
// One reset pipe and one Avalon-MM bridge per bank, all on Clk_100

`include "lmem_macros.svh"

module lmem_shim_top
   import lmem_bus_pkg::*;
   import lmem_ctrl_pkg::*;
(
   input  logic                                   Clk_100,
   input  logic                                   reset,
   // Region side, one entry per bank
   input  lmem_cmd_t [`LMEM_NUM_BANKS-1:0]        s_cmd,
   output logic      [`LMEM_NUM_BANKS-1:0]        s_waitrequest,
   output lmem_rsp_t [`LMEM_NUM_BANKS-1:0]        s_rsp,
   // Memory side, one entry per bank
   output lmem_cmd_t [`LMEM_NUM_BANKS-1:0]        m_cmd,
   input  logic      [`LMEM_NUM_BANKS-1:0]        m_waitrequest,
   input  lmem_rsp_t [`LMEM_NUM_BANKS-1:0]        m_rsp
);

   // Local reset of each bank
   logic [`LMEM_NUM_BANKS-1:0] bank_reset;

   // ========================================
   // Per-bank pipelines
   // ========================================

   // Banks share nothing but the clock and the global reset
   genvar b;
   generate
      for (b = 0; b < `LMEM_NUM_BANKS; b++)
      begin : g_bank
         localparam bank_idx_t BANK = bank_idx_t'(b);

         // Bank reset, released three cycles after the global reset
         lmem_reset_pipe i_reset_pipe
         (
            .Clk_100    (Clk_100),
            .reset      (reset),
            .bank_reset (bank_reset[BANK])
         );

         // Registered command path and read-data pipe
         lmem_avmm_bridge i_bridge
         (
            .Clk_100       (Clk_100),
            .bank_reset    (bank_reset[BANK]),
            .s_cmd         (s_cmd[BANK]),
            .s_waitrequest (s_waitrequest[BANK]),
            .s_rsp         (s_rsp[BANK]),
            .m_cmd         (m_cmd[BANK]),
            .m_waitrequest (m_waitrequest[BANK]),
            .m_rsp         (m_rsp[BANK])
         );
      end
   endgenerate

endmodule

/* verif/lmem_tb_asserts.sv */
// Protocol assertions for one Avalon-MM bridge
// Bound into every bridge instance of the shim

`include "lmem_macros.svh"

module lmem_tb_asserts
   import lmem_bus_pkg::*;
(
   input logic      Clk_100,
   input logic      bank_reset,
   input logic      s_waitrequest,
   input lmem_rsp_t s_rsp,
   input lmem_cmd_t m_cmd,
   input logic      m_waitrequest,
   input lmem_rsp_t m_rsp
);

   // Read back by the testbench for the final report
   int fail_count = 0;

   // Command must hold while the memory stalls it
   assert property (@(posedge Clk_100) disable iff (bank_reset)
      (m_cmd.op != OP_IDLE && m_waitrequest) |=> $stable(m_cmd))
   else
   begin
      $error("m_cmd changed while m_waitrequest was high");
      fail_count++;
   end

   // Read pipe has a fixed latency of two cycles
   assert property (@(posedge Clk_100) disable iff (bank_reset)
      (s_rsp.valid == $past(m_rsp.valid, 2)) &&
      (!s_rsp.valid || s_rsp.readdata == $past(m_rsp.readdata, 2)))
   else
   begin
      $error("s_rsp differs from m_rsp delayed by two cycles");
      fail_count++;
   end

   // Full slots always present a live command to memory
   // The cycle right after bank reset still shows the reset waitrequest
   assert property (@(posedge Clk_100) disable iff (bank_reset)
      (s_waitrequest && !$past(bank_reset)) |-> (m_cmd.op != OP_IDLE))
   else
   begin
      $error("s_waitrequest high while m_cmd was idle");
      fail_count++;
   end

endmodule

/* verif/lmem_tb.sv */
// Testbench for the multi-bank local-memory shim
// Directed tests with per-bank memory responders and typed checks

`include "lmem_macros.svh"

module lmem_tb
   import lmem_bus_pkg::*;
   import lmem_ctrl_pkg::*;
;

   localparam int NB      = `LMEM_NUM_BANKS;
   localparam int TIMEOUT = 400;

   typedef logic [BANK_IDX_W+`LMEM_ADDR_W-1:0] mem_key_t;

   logic                 Clk_100;
   logic                 reset;
   lmem_cmd_t [NB-1:0]   s_cmd;
   logic      [NB-1:0]   s_waitrequest;
   lmem_rsp_t [NB-1:0]   s_rsp;
   lmem_cmd_t [NB-1:0]   m_cmd;
   logic      [NB-1:0]   m_waitrequest;
   lmem_rsp_t [NB-1:0]   m_rsp;

   // Scoreboard state, per bank
   lmem_cmd_t            exp_cmd_q [NB][$];
   lmem_rsp_t            exp_rsp_q [NB][$];
   int                   rsp_cyc_q [NB][$];
   int                   issued [NB];
   int                   mem_acc [NB];
   // 0 no stall, 1 random stall, 2 permanent stall
   int                   stall_mode [NB];
   logic                 rsp_due [NB];
   logic [`LMEM_DATA_W-1:0] rsp_data [NB];
   logic [`LMEM_DATA_W-1:0] mem_model [mem_key_t];

   int    seed = 46;
   int    cyc = 0;
   int    error_count = 0;
   int    timeout_count = 0;
   int    assert_fails [NB];
   logic  reset_done = 1'b0;
   string cur_test = "init";

   lmem_shim_top i_dut
   (
      .Clk_100       (Clk_100),
      .reset         (reset),
      .s_cmd         (s_cmd),
      .s_waitrequest (s_waitrequest),
      .s_rsp         (s_rsp),
      .m_cmd         (m_cmd),
      .m_waitrequest (m_waitrequest),
      .m_rsp         (m_rsp)
   );

   bind lmem_avmm_bridge lmem_tb_asserts i_asserts
   (
      .Clk_100       (Clk_100),
      .bank_reset    (bank_reset),
      .s_waitrequest (s_waitrequest),
      .s_rsp         (s_rsp),
      .m_cmd         (m_cmd),
      .m_waitrequest (m_waitrequest),
      .m_rsp         (m_rsp)
   );

   // Assertion failures of each bank
   for (genvar g = 0; g < NB; g++)
   begin : g_fails
      assign assert_fails[g] = i_dut.g_bank[g].i_bridge.i_asserts.fail_count;
   end

   initial Clk_100 = 1'b0;
   always #10 Clk_100 = ~Clk_100;

   // ========================================
   // Typed compare tasks
   // ========================================

   task automatic check_cmd(input lmem_cmd_t exp, input lmem_cmd_t act);
      if (exp !== act)
      begin
         $display("** Error %s: command expected %h actual %h", cur_test, exp, act);
         error_count++;
      end
   endtask

   task automatic check_rsp(input lmem_rsp_t exp, input lmem_rsp_t act);
      if (exp !== act)
      begin
         $display("** Error %s: response expected %h actual %h", cur_test, exp, act);
         error_count++;
      end
   endtask

   task automatic check_op(input avmm_op_e exp, input avmm_op_e act);
      if (exp !== act)
      begin
         $display("** Error %s: op expected %s actual %s", cur_test, exp.name(), act.name());
         error_count++;
      end
   endtask

   task automatic check_bit(input logic exp, input logic act);
      if (exp !== act)
      begin
         $display("** Error %s: waitrequest expected %b actual %b", cur_test, exp, act);
         error_count++;
      end
   endtask

   // ========================================
   // Memory responder and monitors
   // ========================================

   // Sampled mid-cycle, values match the next rising edge
   always @(negedge Clk_100)
   begin
      mem_key_t key;
      for (int b = 0; b < NB; b++)
      begin
         // Full slots only with two commands in flight
         if (reset_done && s_waitrequest[b] && (issued[b] - mem_acc[b] != 2))
         begin
            $display("Error in %s: bank %0d raised s_waitrequest with %0d outstanding",
                     cur_test, b, issued[b] - mem_acc[b]);
            error_count++;
         end
         // Region side acceptance
         if (s_cmd[b].op != OP_IDLE && s_waitrequest[b] === 1'b0)
         begin
            exp_cmd_q[b].push_back(s_cmd[b]);
            issued[b]++;
         end
         // Memory side acceptance
         rsp_due[b] = 1'b0;
         if (m_cmd[b].op != OP_IDLE && m_waitrequest[b] === 1'b0)
         begin
            mem_acc[b]++;
            key = {bank_idx_t'(b), m_cmd[b].address};
            if (exp_cmd_q[b].size() == 0)
            begin
               $display("Error in %s: bank %0d memory saw a command nobody issued",
                        cur_test, b);
               error_count++;
            end
            else
               check_cmd(exp_cmd_q[b].pop_front(), m_cmd[b]);
            if (m_cmd[b].op == OP_WRITE)
               mem_model[key] = m_cmd[b].writedata;
            else if (m_cmd[b].op == OP_READ)
            begin
               rsp_due[b]  = 1'b1;
               rsp_data[b] = mem_model.exists(key) ? mem_model[key] : {2{4'b0, key}};
            end
         end
         // Region side read data
         if (s_rsp[b].valid === 1'b1)
         begin
            if (exp_rsp_q[b].size() == 0)
            begin
               $display("Error in %s: bank %0d returned read data nobody asked for",
                        cur_test, b);
               error_count++;
            end
            else
            begin
               check_rsp(exp_rsp_q[b].pop_front(), s_rsp[b]);
               if (rsp_cyc_q[b].size() == 0 || cyc - rsp_cyc_q[b].pop_front() != 2)
               begin
                  $display("Error in %s: bank %0d read data not two cycles after memory",
                           cur_test, b);
                  error_count++;
               end
            end
         end
      end
   end

   // Memory side outputs, driven just after the edge
   always @(posedge Clk_100)
   begin
      cyc++;
      #2;
      for (int b = 0; b < NB; b++)
      begin
         m_rsp[b] = rsp_due[b] ? {1'b1, rsp_data[b]} : '0;
         if (rsp_due[b])
            rsp_cyc_q[b].push_back(cyc);
         case (stall_mode[b])
            1:       m_waitrequest[b] = 1'($random(seed) & 1);
            2:       m_waitrequest[b] = 1'b1;
            default: m_waitrequest[b] = 1'b0;
         endcase
      end
   end

   // ========================================
   // Driver helpers
   // ========================================

   function automatic lmem_cmd_t make_cmd(input avmm_op_e op, input int addr,
                                          input logic [`LMEM_DATA_W-1:0] data);
      lmem_cmd_t c;
      c.op         = op;
      c.address    = `LMEM_ADDR_W'(addr);
      c.burstcount = `LMEM_BURST_W'(addr % 5 + 1);
      c.writedata  = (op == OP_WRITE) ? data : '0;
      c.byteenable = `LMEM_BYTE_W'(8'hFF >> (addr % 3));
      return c;
   endfunction

   // Data written to an address, known to the tests
   function automatic logic [`LMEM_DATA_W-1:0] pattern(input int b, input int addr);
      return 64'h0F1E_2D3C_4B5A_6978 ^ {32'(b + 1), 32'(addr * 7 + 3)};
   endfunction

   // Assumes the caller runs just after a rising edge
   task automatic drive_cmd(input int b, input lmem_cmd_t cmd);
      int waited;
      waited   = 0;
      s_cmd[b] = cmd;
      @(negedge Clk_100);
      while (s_waitrequest[b] !== 1'b0 && waited < TIMEOUT)
      begin
         waited++;
         @(negedge Clk_100);
      end
      if (waited >= TIMEOUT)
      begin
         $display("Timeout in %s: bank %0d never accepted a command", cur_test, b);
         timeout_count++;
      end
      @(posedge Clk_100);
      #2;
      s_cmd[b] = make_cmd(OP_IDLE, 0, '0);
   endtask

   task automatic issue_read(input int b, input int addr);
      exp_rsp_q[b].push_back({1'b1, pattern(b, addr)});
      drive_cmd(b, make_cmd(OP_READ, addr, '0));
   endtask

   task automatic write_stream(input int b, input int base, input int n);
      for (int i = 0; i < n; i++)
         drive_cmd(b, make_cmd(OP_WRITE, base + i, pattern(b, base + i)));
   endtask

   // Waits until every command and read of a bank has come through
   task automatic wait_drain(input int b);
      int waited;
      waited = 0;
      while ((exp_cmd_q[b].size() != 0 || exp_rsp_q[b].size() != 0) && waited < TIMEOUT)
      begin
         waited++;
         @(negedge Clk_100);
      end
      if (waited >= TIMEOUT)
      begin
         $display("Timeout in %s: bank %0d did not drain its commands", cur_test, b);
         timeout_count++;
      end
      @(posedge Clk_100);
      #2;
   endtask

   // Changed mid-cycle so the responder sees it at the next edge
   task automatic set_stall(input int b, input int mode);
      @(negedge Clk_100);
      stall_mode[b] = mode;
      @(posedge Clk_100);
      #2;
   endtask

   // ========================================
   // Directed tests
   // ========================================

   task automatic reset_sequence();
      cur_test = "reset";
      for (int i = 0; i < 4; i++)
      begin
         @(posedge Clk_100);
         #2;
         if (i == 3)
            reset = 1'b0;
         @(negedge Clk_100);
         // First edge only loads the bank reset, waitrequest follows one edge later
         if (i > 0)
         begin
            for (int b = 0; b < NB; b++)
            begin
               check_bit(1'b1, s_waitrequest[b]);
               check_op(OP_IDLE, m_cmd[b].op);
            end
         end
      end
      // Bank reset trails the global reset by three cycles
      for (int k = 0; k < 4; k++)
      begin
         @(negedge Clk_100);
         for (int b = 0; b < NB; b++)
         begin
            check_bit(k < 3, s_waitrequest[b]);
            check_op(OP_IDLE, m_cmd[b].op);
         end
      end
      reset_done = 1'b1;
      @(posedge Clk_100);
      #2;
   endtask

   task automatic write_passthrough();
      cur_test = "write_passthrough";
      write_stream(0, 16, 6);
      wait_drain(0);
      if (mem_acc[1] != 0)
      begin
         $display("Error in %s: bank 1 saw commands while only bank 0 was used", cur_test);
         error_count++;
      end
   endtask

   task automatic backpressure_stream();
      cur_test = "backpressure";
      set_stall(0, 1);
      set_stall(1, 1);
      fork
         write_stream(0, 100, 20);
         write_stream(1, 200, 20);
      join
      wait_drain(0);
      wait_drain(1);
      set_stall(0, 0);
      set_stall(1, 0);
   endtask

   task automatic read_path();
      cur_test = "read_path";
      // Reads go back to back, several in flight
      for (int i = 0; i < 6; i++)
         issue_read(0, 100 + i);
      set_stall(1, 1);
      for (int i = 0; i < 6; i++)
         issue_read(1, 219 - i);
      wait_drain(0);
      wait_drain(1);
      set_stall(1, 0);
   endtask

   task automatic bank_independence();
      cur_test = "bank_independence";
      set_stall(0, 2);
      // Two commands fill both slots of the stalled bank
      drive_cmd(0, make_cmd(OP_WRITE, 300, pattern(0, 300)));
      issue_read(0, 300);
      write_stream(1, 400, 5);
      for (int i = 0; i < 5; i++)
         issue_read(1, 400 + i);
      wait_drain(1);
      if (exp_cmd_q[0].size() != 2 || s_waitrequest[0] !== 1'b1)
      begin
         $display("Error in %s: stalled bank 0 did not hold its two commands", cur_test);
         error_count++;
      end
      set_stall(0, 0);
      wait_drain(0);
   endtask

   // ========================================
   // Main sequence
   // ========================================

   initial
   begin
      int total;
      reset         = 1'b1;
      m_waitrequest = '0;
      m_rsp         = '0;
      for (int b = 0; b < NB; b++)
      begin
         s_cmd[b]      = make_cmd(OP_IDLE, 0, '0);
         issued[b]     = 0;
         mem_acc[b]    = 0;
         stall_mode[b] = 0;
         rsp_due[b]    = 1'b0;
         rsp_data[b]   = '0;
      end

      reset_sequence();
      write_passthrough();
      backpressure_stream();
      read_path();
      bank_independence();

      cur_test = "final";
      for (int b = 0; b < NB; b++)
      begin
         if (issued[b] != mem_acc[b])
         begin
            $display("Error in %s: bank %0d issued %0d commands but memory took %0d",
                     cur_test, b, issued[b], mem_acc[b]);
            error_count++;
         end
      end
      repeat (4) @(posedge Clk_100);

      total = 0;
      for (int b = 0; b < NB; b++)
         total += assert_fails[b];
      $display("Errors: %0d compare, %0d timeout, %0d assertion",
               error_count, timeout_count, total);
      if (error_count == 0 && timeout_count == 0 && total == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* compile.f */
+incdir+src
src/lmem_bus_pkg.sv
src/lmem_ctrl_pkg.sv
src/lmem_reset_pipe.sv
src/lmem_avmm_bridge.sv
src/lmem_shim_top.sv
verif/lmem_tb_asserts.sv
verif/lmem_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the local-memory shim testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   -f compile.f --top-module lmem_tb -o lmem_sim

# Run the simulation, the log decides the result
./obj_dir/lmem_sim +verilator+error+limit+1000 > run.log 2>&1 || true
cat run.log

if grep -q "PASS: all tests" run.log
then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi
